//--- common/decodePkg.sv
// Encodings here are internal to the core and cover RV32I only, with no RV64I word forms
package decodePkg;

    localparam int InstrWidth = 32;
    localparam int ByteLanes  = 4;

    typedef logic [6:0] opcodeT;
    typedef logic [2:0] funct3T;
    typedef logic [6:0] funct7T;

    // RV32I major opcodes
    localparam opcodeT OpReg    = 7'b0110011;
    localparam opcodeT OpImm    = 7'b0010011;
    localparam opcodeT OpLoad   = 7'b0000011;
    localparam opcodeT OpStore  = 7'b0100011;
    localparam opcodeT OpLui    = 7'b0110111;
    localparam opcodeT OpAuipc  = 7'b0010111;
    localparam opcodeT OpJal    = 7'b1101111;
    localparam opcodeT OpJalr   = 7'b1100111;
    localparam opcodeT OpBranch = 7'b1100011;

    typedef enum logic [1:0] {
        PcPlus4,
        JumpReg,
        JumpCompute,
        BranchCond
    } pcSrcT;

    typedef enum logic [2:0] {
        NoBranch,
        Beq,
        Bne,
        Blt,
        Bge,
        Bltu,
        Bgeu
    } condPcSrcT;

    typedef enum logic [2:0] {
        ImmI,
        ImmShamt,
        ImmS,
        ImmB,
        ImmU,
        ImmJ
    } immSrcT;

    // Second operand of the PC adder
    typedef enum logic {
        PcPlusImm,
        PcPlus4Upd
    } updatedPcSrcT;

    typedef enum logic {
        SrcRs2,
        SrcImm
    } aluSrcBT;

    typedef enum logic [3:0] {
        Add,
        Sub,
        And,
        Or,
        Xor,
        Sll,
        Slt,
        Sltu,
        Srl,
        Sra
    } aluOpT;

    typedef enum logic [1:0] {
        FromAlu,
        FromAluOpB,
        FromUpdatedPc
    } computeSrcT;

    typedef enum logic {
        FromCompute,
        FromMemory
    } resultSrcT;

    // Load data extension
    typedef enum logic [2:0] {
        NoTrunc,
        TruncByte,
        TruncHalf,
        TruncWord,
        TruncByteU,
        TruncHalfU
    } truncSrcT;

endpackage

//--- decoder/aluOpDecoder.sv
// Decodes OP and OP-IMM only and expects the caller to have checked the opcode already
`timescale 1ns/1ns

module aluOpDecoder (
    input  decodePkg::funct7T funct7,
    input  decodePkg::funct3T funct3,
    input  logic              immForm,
    output decodePkg::aluOpT  aluOp,
    output decodePkg::immSrcT immSrc,
    output logic              legal
);
    import decodePkg::*;

    always_comb begin
        aluOp  = Add;
        immSrc = ImmI;
        legal  = 1'b1;
        if (immForm) begin
            // funct7 only matters for the shifts
            case (funct3)
                3'b000: aluOp = Add;
                3'b010: aluOp = Slt;
                3'b011: aluOp = Sltu;
                3'b100: aluOp = Xor;
                3'b110: aluOp = Or;
                3'b111: aluOp = And;
                3'b001: begin
                    immSrc = ImmShamt;
                    aluOp  = Sll;
                    legal  = (funct7 == 7'b0000000);
                end
                3'b101: begin
                    immSrc = ImmShamt;
                    case (funct7)
                        7'b0000000: aluOp = Srl;
                        7'b0100000: aluOp = Sra;
                        default:    legal = 1'b0;
                    endcase
                end
                default: legal = 1'b0;
            endcase
        end else begin
            case ({funct7, funct3})
                10'b0000000_000: aluOp = Add;
                10'b0100000_000: aluOp = Sub;
                10'b0000000_001: aluOp = Sll;
                10'b0000000_010: aluOp = Slt;
                10'b0000000_011: aluOp = Sltu;
                10'b0000000_100: aluOp = Xor;
                10'b0000000_101: aluOp = Srl;
                10'b0100000_101: aluOp = Sra;
                10'b0000000_110: aluOp = Or;
                10'b0000000_111: aluOp = And;
                default:         legal = 1'b0;
            endcase
        end
    end

endmodule

//--- decoder/flowDecoder.sv
// Handles LUI, AUIPC, JAL, JALR and branches only and accepts JALR with any funct3
`timescale 1ns/1ns

module flowDecoder (
    input  decodePkg::opcodeT       opcode,
    input  decodePkg::funct3T       funct3,
    output decodePkg::pcSrcT        pcSrc,
    output decodePkg::condPcSrcT    condPcSrc,
    output decodePkg::updatedPcSrcT updatedPcSrc,
    output decodePkg::immSrcT       immSrc,
    output decodePkg::aluSrcBT      aluSrcB,
    output decodePkg::computeSrcT   computeSrc,
    output logic                    legal
);
    import decodePkg::*;

    always_comb begin
        pcSrc        = PcPlus4;
        condPcSrc    = NoBranch;
        updatedPcSrc = PcPlus4Upd;
        immSrc       = ImmU;
        aluSrcB      = SrcImm;
        computeSrc   = FromUpdatedPc;
        legal        = 1'b1;
        case (opcode)
            // Immediate passes straight through operand B
            OpLui: computeSrc = FromAluOpB;
            OpAuipc: updatedPcSrc = PcPlusImm;
            OpJal: begin
                pcSrc  = JumpReg;
                immSrc = ImmJ;
            end
            OpJalr: begin
                pcSrc  = JumpCompute;
                immSrc = ImmI;
            end
            OpBranch: begin
                pcSrc        = BranchCond;
                immSrc       = ImmB;
                aluSrcB      = SrcRs2;
                updatedPcSrc = PcPlusImm;
                case (funct3)
                    3'b000:  condPcSrc = Beq;
                    3'b001:  condPcSrc = Bne;
                    3'b100:  condPcSrc = Blt;
                    3'b101:  condPcSrc = Bge;
                    3'b110:  condPcSrc = Bltu;
                    3'b111:  condPcSrc = Bgeu;
                    default: legal     = 1'b0;
                endcase
            end
            default: legal = 1'b0;
        endcase
    end

endmodule

//--- decoder/instrDecoder.sv
// Purely combinational and leaves fields a class does not use at fixed but meaningless values
`timescale 1ns/1ns

module instrDecoder (
    input  logic [decodePkg::InstrWidth-1:0] instr,
    output logic                             regWrite,
    output logic                             memEn,
    output logic                             memWrite,
    output logic [decodePkg::ByteLanes-1:0]  byteEn,
    output decodePkg::pcSrcT                 pcSrc,
    output decodePkg::condPcSrcT             condPcSrc,
    output decodePkg::immSrcT                immSrc,
    output decodePkg::updatedPcSrcT          updatedPcSrc,
    output decodePkg::aluSrcBT               aluSrcB,
    output decodePkg::aluOpT                 aluOp,
    output decodePkg::computeSrcT            computeSrc,
    output decodePkg::resultSrcT             resultSrc,
    output decodePkg::truncSrcT              truncSrc,
    output logic                             illegalInstr
);
    import decodePkg::*;

    opcodeT                 opcode;
    funct3T                 funct3;
    funct7T                 funct7;
    logic                   immForm;
    logic                   isStore;
    logic                   legal;
    aluOpT                  aluOpAlu;
    immSrcT                 immSrcAlu;
    logic                   legalAlu;
    truncSrcT               truncSrcMem;
    logic [ByteLanes-1:0]   byteEnMem;
    logic                   legalMem;
    pcSrcT                  pcSrcFlow;
    condPcSrcT              condPcSrcFlow;
    updatedPcSrcT           updatedPcSrcFlow;
    immSrcT                 immSrcFlow;
    aluSrcBT                aluSrcBFlow;
    computeSrcT             computeSrcFlow;
    logic                   legalFlow;

    assign opcode  = instr[6:0];
    assign funct3  = instr[14:12];
    assign funct7  = instr[31:25];
    assign immForm = (opcode == OpImm);
    assign isStore = (opcode == OpStore);

    aluOpDecoder aluDec (
        .funct7 (funct7),
        .funct3 (funct3),
        .immForm(immForm),
        .aluOp  (aluOpAlu),
        .immSrc (immSrcAlu),
        .legal  (legalAlu)
    );

    memOpDecoder memDec (
        .funct3  (funct3),
        .isStore (isStore),
        .truncSrc(truncSrcMem),
        .byteEn  (byteEnMem),
        .legal   (legalMem)
    );

    flowDecoder flowDec (
        .opcode      (opcode),
        .funct3      (funct3),
        .pcSrc       (pcSrcFlow),
        .condPcSrc   (condPcSrcFlow),
        .updatedPcSrc(updatedPcSrcFlow),
        .immSrc      (immSrcFlow),
        .aluSrcB     (aluSrcBFlow),
        .computeSrc  (computeSrcFlow),
        .legal       (legalFlow)
    );

    always_comb begin
        regWrite     = 1'b0;
        memEn        = 1'b0;
        memWrite     = 1'b0;
        byteEn       = '0;
        pcSrc        = PcPlus4;
        condPcSrc    = NoBranch;
        immSrc       = ImmI;
        updatedPcSrc = PcPlus4Upd;
        aluSrcB      = SrcImm;
        aluOp        = Add;
        computeSrc   = FromAlu;
        resultSrc    = FromCompute;
        truncSrc     = NoTrunc;
        legal        = 1'b0;
        case (opcode)
            OpReg, OpImm: begin
                legal    = legalAlu;
                regWrite = legalAlu;
                aluOp    = aluOpAlu;
                immSrc   = immSrcAlu;
                if (!immForm) begin
                    aluSrcB = SrcRs2;
                end
            end
            // Address is rs1 plus immediate through the ALU
            OpLoad: begin
                legal     = legalMem;
                regWrite  = legalMem;
                memEn     = legalMem;
                resultSrc = FromMemory;
                truncSrc  = truncSrcMem;
            end
            OpStore: begin
                legal    = legalMem;
                memEn    = legalMem;
                memWrite = legalMem;
                byteEn   = legalMem ? byteEnMem : '0;
                immSrc   = ImmS;
            end
            OpLui, OpAuipc, OpJal, OpJalr, OpBranch: begin
                legal        = legalFlow;
                regWrite     = legalFlow && (opcode != OpBranch);
                pcSrc        = pcSrcFlow;
                condPcSrc    = condPcSrcFlow;
                immSrc       = immSrcFlow;
                updatedPcSrc = updatedPcSrcFlow;
                aluSrcB      = aluSrcBFlow;
                computeSrc   = computeSrcFlow;
                // Branch compare uses the subtractor flags
                if (opcode == OpBranch) begin
                    aluOp = Sub;
                end
            end
            default: legal = 1'b0;
        endcase
        illegalInstr = !legal;
    end

endmodule

//--- decoder/memOpDecoder.sv
// Byte enables assume a little-endian word with the address offset applied later in the core
`timescale 1ns/1ns

module memOpDecoder (
    input  decodePkg::funct3T                 funct3,
    input  logic                              isStore,
    output decodePkg::truncSrcT               truncSrc,
    output logic [decodePkg::ByteLanes-1:0]   byteEn,
    output logic                              legal
);
    import decodePkg::*;

    always_comb begin
        truncSrc = NoTrunc;
        byteEn   = '0;
        legal    = 1'b1;
        if (isStore) begin
            // SB, SH, SW
            case (funct3)
                3'b000:  byteEn[0]   = 1'b1;
                3'b001:  byteEn[1:0] = 2'b11;
                3'b010:  byteEn      = '1;
                default: legal       = 1'b0;
            endcase
        end else begin
            case (funct3)
                3'b000:  truncSrc = TruncByte;
                3'b001:  truncSrc = TruncHalf;
                3'b010:  truncSrc = TruncWord;
                3'b100:  truncSrc = TruncByteU;
                3'b101:  truncSrc = TruncHalfU;
                default: legal    = 1'b0;
            endcase
        end
    end

endmodule

//--- hdl/decodeStage.sv
// One instruction per cycle with no stall input, and payload fields hold while ctrlValid is low
`timescale 1ns/1ns

module decodeStage (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [decodePkg::InstrWidth-1:0] instr,
    input  logic                             instrValid,
    output logic                             ctrlValid,
    output logic                             regWrite,
    output logic                             memEn,
    output logic                             memWrite,
    output logic [decodePkg::ByteLanes-1:0]  byteEn,
    output decodePkg::pcSrcT                 pcSrc,
    output decodePkg::condPcSrcT             condPcSrc,
    output decodePkg::immSrcT                immSrc,
    output decodePkg::updatedPcSrcT          updatedPcSrc,
    output decodePkg::aluSrcBT               aluSrcB,
    output decodePkg::aluOpT                 aluOp,
    output decodePkg::computeSrcT            computeSrc,
    output decodePkg::resultSrcT             resultSrc,
    output decodePkg::truncSrcT              truncSrc,
    output logic                             illegalInstr
);
    import decodePkg::*;

    logic                 decRegWrite;
    logic                 decMemEn;
    logic                 decMemWrite;
    logic [ByteLanes-1:0] decByteEn;
    pcSrcT                decPcSrc;
    condPcSrcT            decCondPcSrc;
    immSrcT               decImmSrc;
    updatedPcSrcT         decUpdatedPcSrc;
    aluSrcBT              decAluSrcB;
    aluOpT                decAluOp;
    computeSrcT           decComputeSrc;
    resultSrcT            decResultSrc;
    truncSrcT             decTruncSrc;
    logic                 decIllegal;

    instrDecoder decoder (
        .instr       (instr),
        .regWrite    (decRegWrite),
        .memEn       (decMemEn),
        .memWrite    (decMemWrite),
        .byteEn      (decByteEn),
        .pcSrc       (decPcSrc),
        .condPcSrc   (decCondPcSrc),
        .immSrc      (decImmSrc),
        .updatedPcSrc(decUpdatedPcSrc),
        .aluSrcB     (decAluSrcB),
        .aluOp       (decAluOp),
        .computeSrc  (decComputeSrc),
        .resultSrc   (decResultSrc),
        .truncSrc    (decTruncSrc),
        .illegalInstr(decIllegal)
    );

    // Enables drop on bubbles so downstream stages see a no-op
    always_ff @(posedge clk) begin
        if (reset) begin
            ctrlValid    <= 1'b0;
            regWrite     <= 1'b0;
            memEn        <= 1'b0;
            memWrite     <= 1'b0;
            byteEn       <= '0;
            illegalInstr <= 1'b0;
        end else begin
            ctrlValid    <= instrValid;
            regWrite     <= instrValid && decRegWrite;
            memEn        <= instrValid && decMemEn;
            memWrite     <= instrValid && decMemWrite;
            byteEn       <= instrValid ? decByteEn : '0;
            illegalInstr <= instrValid && decIllegal;
        end
    end

    always_ff @(posedge clk) begin
        if (instrValid) begin
            pcSrc        <= decPcSrc;
            condPcSrc    <= decCondPcSrc;
            immSrc       <= decImmSrc;
            updatedPcSrc <= decUpdatedPcSrc;
            aluSrcB      <= decAluSrcB;
            aluOp        <= decAluOp;
            computeSrc   <= decComputeSrc;
            resultSrc    <= decResultSrc;
            truncSrc     <= decTruncSrc;
        end
    end

endmodule

//--- tb.f
common/decodePkg.sv
decoder/aluOpDecoder.sv
decoder/memOpDecoder.sv
decoder/flowDecoder.sv
decoder/instrDecoder.sv
hdl/decodeStage.sv
verif/decodeStage_chk.sv
verif/decodeStage_tb.sv

//--- verif/decodeStage_chk.sv
// Rules hold on registered outputs only and are not checked while reset is high
`timescale 1ns/1ns

module decodeStage_chk (
    input logic                            clk,
    input logic                            reset,
    input logic                            ctrlValid,
    input logic                            regWrite,
    input logic                            memEn,
    input logic                            memWrite,
    input logic [decodePkg::ByteLanes-1:0] byteEn,
    input logic                            illegalInstr
);

    // Failed assertions so far
    int failCount;

    initial failCount = 0;

    // A store is always a memory access
    storeNeedsMemEn: assert property (@(posedge clk) disable iff (reset)
        memWrite |-> memEn)
        else begin
            $error("memWrite high without memEn");
            failCount++;
        end

    storeNoRegWrite: assert property (@(posedge clk) disable iff (reset)
        memWrite |-> !regWrite)
        else begin
            $error("memWrite and regWrite high together");
            failCount++;
        end

    byteEnOnlyOnStore: assert property (@(posedge clk) disable iff (reset)
        (byteEn != '0) |-> memWrite)
        else begin
            $error("byteEn set without memWrite");
            failCount++;
        end

    // Trapping instruction must not touch state
    illegalNoEnables: assert property (@(posedge clk) disable iff (reset)
        illegalInstr |-> !(regWrite || memEn || memWrite || (byteEn != '0)))
        else begin
            $error("illegalInstr high with an enable set");
            failCount++;
        end

    bubbleNoEnables: assert property (@(posedge clk) disable iff (reset)
        !ctrlValid |-> !(regWrite || memEn || memWrite || illegalInstr))
        else begin
            $error("enable set while ctrlValid is low");
            failCount++;
        end

endmodule

//--- verif/decodeStage_tb.sv
// Payload fields are compared only where the instruction class defines them, enables always
`timescale 1ns/1ns

module decodeStage_tb;
    import decodePkg::*;

    localparam int TimeoutCycles = 3000;
    localparam int RandomCount   = 2000;

    // Field mask bit positions
    localparam int MPc      = 0;
    localparam int MCond    = 1;
    localparam int MImm     = 2;
    localparam int MUpd     = 3;
    localparam int MSrcB    = 4;
    localparam int MAluOp   = 5;
    localparam int MCompute = 6;
    localparam int MResult  = 7;
    localparam int MTrunc   = 8;

    typedef struct packed {
        logic       regWrite;
        logic       memEn;
        logic       memWrite;
        logic [3:0] byteEn;
        logic [1:0] pcSrc;
        logic [2:0] condPcSrc;
        logic [2:0] immSrc;
        logic       updatedPcSrc;
        logic       aluSrcB;
        logic [3:0] aluOp;
        logic [1:0] computeSrc;
        logic       resultSrc;
        logic [2:0] truncSrc;
        logic       illegal;
    } ctrlT;

    typedef struct packed {
        logic        valid;
        ctrlT        ctrl;
        logic [8:0]  mask;
    } expT;

    logic                 clk;
    logic                 reset;
    logic [31:0]          instr;
    logic                 instrValid;
    logic                 ctrlValid;
    logic                 regWrite;
    logic                 memEn;
    logic                 memWrite;
    logic [ByteLanes-1:0] byteEn;
    pcSrcT                pcSrc;
    condPcSrcT            condPcSrc;
    immSrcT               immSrc;
    updatedPcSrcT         updatedPcSrc;
    aluSrcBT              aluSrcB;
    aluOpT                aluOp;
    computeSrcT           computeSrc;
    resultSrcT            resultSrc;
    truncSrcT             truncSrc;
    logic                 illegalInstr;

    expT expQueue[$];
    int  pushedCount;
    int  checkedCount;
    int  cycleCount;

    decodeStage DUT (
        .clk         (clk),
        .reset       (reset),
        .instr       (instr),
        .instrValid  (instrValid),
        .ctrlValid   (ctrlValid),
        .regWrite    (regWrite),
        .memEn       (memEn),
        .memWrite    (memWrite),
        .byteEn      (byteEn),
        .pcSrc       (pcSrc),
        .condPcSrc   (condPcSrc),
        .immSrc      (immSrc),
        .updatedPcSrc(updatedPcSrc),
        .aluSrcB     (aluSrcB),
        .aluOp       (aluOp),
        .computeSrc  (computeSrc),
        .resultSrc   (resultSrc),
        .truncSrc    (truncSrc),
        .illegalInstr(illegalInstr)
    );

    bind decodeStage decodeStage_chk chk (
        .clk         (clk),
        .reset       (reset),
        .ctrlValid   (ctrlValid),
        .regWrite    (regWrite),
        .memEn       (memEn),
        .memWrite    (memWrite),
        .byteEn      (byteEn),
        .illegalInstr(illegalInstr)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // RV32I decode table, mask marks the fields the class defines
    function automatic ctrlT refDecode(input logic [31:0] word, output logic [8:0] mask);
        ctrlT       c;
        logic [6:0] op;
        logic [2:0] f3;
        logic [6:0] f7;
        logic       immForm;
        c       = '0;
        mask    = '1;
        op      = word[6:0];
        f3      = word[14:12];
        f7      = word[31:25];
        immForm = (op == OpImm);
        c.pcSrc      = PcPlus4;
        c.condPcSrc  = NoBranch;
        c.resultSrc  = FromCompute;
        c.aluOp      = Add;
        c.aluSrcB    = SrcImm;
        case (op)
            OpReg, OpImm: begin
                c.regWrite   = 1'b1;
                c.computeSrc = FromAlu;
                c.aluSrcB    = immForm ? SrcImm : SrcRs2;
                c.immSrc     = ImmI;
                mask[MUpd]   = 1'b0;
                mask[MTrunc] = 1'b0;
                mask[MImm]   = immForm;
                case (f3)
                    3'b000: begin
                        c.aluOp   = (!immForm && f7 == 7'h20) ? Sub : Add;
                        c.illegal = !(immForm || f7 == 7'h00 || f7 == 7'h20);
                    end
                    3'b001: begin
                        c.aluOp   = Sll;
                        c.immSrc  = ImmShamt;
                        c.illegal = (f7 != 7'h00);
                    end
                    3'b101: begin
                        c.aluOp   = (f7 == 7'h20) ? Sra : Srl;
                        c.immSrc  = ImmShamt;
                        c.illegal = !(f7 == 7'h00 || f7 == 7'h20);
                    end
                    default: begin
                        c.aluOp   = (f3 == 3'b010) ? Slt : (f3 == 3'b011) ? Sltu :
                                    (f3 == 3'b100) ? Xor : (f3 == 3'b110) ? Or : And;
                        c.illegal = !(immForm || f7 == 7'h00);
                    end
                endcase
            end
            OpLoad: begin
                c.regWrite     = 1'b1;
                c.memEn        = 1'b1;
                c.resultSrc    = FromMemory;
                c.immSrc       = ImmI;
                mask[MUpd]     = 1'b0;
                mask[MCompute] = 1'b0;
                case (f3)
                    3'b000:  c.truncSrc = TruncByte;
                    3'b001:  c.truncSrc = TruncHalf;
                    3'b010:  c.truncSrc = TruncWord;
                    3'b100:  c.truncSrc = TruncByteU;
                    3'b101:  c.truncSrc = TruncHalfU;
                    default: c.illegal  = 1'b1;
                endcase
            end
            OpStore: begin
                c.memEn        = 1'b1;
                c.memWrite     = 1'b1;
                c.immSrc       = ImmS;
                mask[MUpd]     = 1'b0;
                mask[MCompute] = 1'b0;
                mask[MResult]  = 1'b0;
                mask[MTrunc]   = 1'b0;
                case (f3)
                    3'b000:  c.byteEn  = 4'b0001;
                    3'b001:  c.byteEn  = 4'b0011;
                    3'b010:  c.byteEn  = 4'b1111;
                    default: c.illegal = 1'b1;
                endcase
            end
            OpLui: begin
                c.regWrite   = 1'b1;
                c.immSrc     = ImmU;
                c.computeSrc = FromAluOpB;
                mask[MUpd]   = 1'b0;
                mask[MAluOp] = 1'b0;
                mask[MTrunc] = 1'b0;
            end
            OpAuipc, OpJal: begin
                c.regWrite     = 1'b1;
                c.computeSrc   = FromUpdatedPc;
                c.immSrc       = (op == OpJal) ? ImmJ : ImmU;
                c.pcSrc        = (op == OpJal) ? JumpReg : PcPlus4;
                c.updatedPcSrc = (op == OpJal) ? PcPlus4Upd : PcPlusImm;
                mask[MSrcB]    = 1'b0;
                mask[MAluOp]   = 1'b0;
                mask[MTrunc]   = 1'b0;
            end
            OpJalr: begin
                c.regWrite     = 1'b1;
                c.pcSrc        = JumpCompute;
                c.immSrc       = ImmI;
                c.updatedPcSrc = PcPlus4Upd;
                c.computeSrc   = FromUpdatedPc;
                mask[MTrunc]   = 1'b0;
            end
            OpBranch: begin
                c.pcSrc        = BranchCond;
                c.immSrc       = ImmB;
                c.aluSrcB      = SrcRs2;
                c.aluOp        = Sub;
                c.updatedPcSrc = PcPlusImm;
                mask[MCompute] = 1'b0;
                mask[MResult]  = 1'b0;
                mask[MTrunc]   = 1'b0;
                case (f3)
                    3'b000:  c.condPcSrc = Beq;
                    3'b001:  c.condPcSrc = Bne;
                    3'b100:  c.condPcSrc = Blt;
                    3'b101:  c.condPcSrc = Bge;
                    3'b110:  c.condPcSrc = Bltu;
                    3'b111:  c.condPcSrc = Bgeu;
                    default: c.illegal   = 1'b1;
                endcase
            end
            default: c.illegal = 1'b1;
        endcase
        if (c.illegal) begin
            c         = '0;
            c.illegal = 1'b1;
            mask      = '0;
        end
        return c;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAIL t=%0t %s: got %0h, expected %0h", $time, name, actual, expected);
            $display("TESTBENCH FAILED");
            $fatal(1, "Output mismatch on %s", name);
        end
    endtask

    task automatic compareOutputs(input expT e);
        checkValue("ctrlValid", ctrlValid, e.valid);
        checkValue("regWrite", regWrite, e.ctrl.regWrite);
        checkValue("memEn", memEn, e.ctrl.memEn);
        checkValue("memWrite", memWrite, e.ctrl.memWrite);
        checkValue("byteEn", byteEn, e.ctrl.byteEn);
        checkValue("illegalInstr", illegalInstr, e.ctrl.illegal);
        if (e.mask[MPc])      checkValue("pcSrc", pcSrc, e.ctrl.pcSrc);
        if (e.mask[MCond])    checkValue("condPcSrc", condPcSrc, e.ctrl.condPcSrc);
        if (e.mask[MImm])     checkValue("immSrc", immSrc, e.ctrl.immSrc);
        if (e.mask[MUpd])     checkValue("updatedPcSrc", updatedPcSrc, e.ctrl.updatedPcSrc);
        if (e.mask[MSrcB])    checkValue("aluSrcB", aluSrcB, e.ctrl.aluSrcB);
        if (e.mask[MAluOp])   checkValue("aluOp", aluOp, e.ctrl.aluOp);
        if (e.mask[MCompute]) checkValue("computeSrc", computeSrc, e.ctrl.computeSrc);
        if (e.mask[MResult])  checkValue("resultSrc", resultSrc, e.ctrl.resultSrc);
        if (e.mask[MTrunc])   checkValue("truncSrc", truncSrc, e.ctrl.truncSrc);
    endtask

    task automatic driveInstr(input logic valid, input logic [31:0] word);
        expT        e;
        logic [8:0] mask;
        @(negedge clk);
        instrValid = valid;
        instr      = word;
        e.valid    = valid;
        e.ctrl     = refDecode(word, mask);
        e.mask     = mask;
        // Bubble: only the cleared enables are defined
        if (!valid) begin
            e.ctrl = '0;
            e.mask = '0;
        end
        expQueue.push_back(e);
        pushedCount++;
    endtask

    function automatic logic [31:0] randomInstr();
        logic [31:0] w;
        w = $urandom;
        if ($urandom_range(0, 3) != 0) begin
            case ($urandom_range(0, 8))
                0:       w[6:0] = OpReg;
                1:       w[6:0] = OpImm;
                2:       w[6:0] = OpLoad;
                3:       w[6:0] = OpStore;
                4:       w[6:0] = OpLui;
                5:       w[6:0] = OpAuipc;
                6:       w[6:0] = OpJal;
                7:       w[6:0] = OpJalr;
                default: w[6:0] = OpBranch;
            endcase
            // Mostly funct7 values that ALU decode accepts
            if ($urandom_range(0, 3) != 0) begin
                w[31:25] = ($urandom_range(0, 1) == 1) ? 7'h20 : 7'h00;
            end
        end
        return w;
    endfunction

    initial begin : compareProc
        expT cur;
        forever begin
            @(posedge clk);
            if (expQueue.size() > 0) begin
                cur = expQueue.pop_front();
                @(negedge clk);
                compareOutputs(cur);
                checkedCount++;
            end
        end
    end

    initial begin
        cycleCount = 0;
        forever begin
            @(negedge clk);
            cycleCount++;
            if (DUT.chk.failCount != 0) begin
                $display("Assertion in the bound checker failed at t=%0t", $time);
                $display("TESTBENCH FAILED");
                $fatal(1, "Checker assertion failure");
            end else if (cycleCount >= TimeoutCycles) begin
                $display("Timeout: run did not finish within %0d cycles", TimeoutCycles);
                $display("TESTBENCH FAILED");
                $fatal(1, "Simulation timed out");
            end
        end
    end

    initial begin
        logic [6:0] f7List [3];
        void'($urandom(32'h2457d9c5));
        f7List[0]    = 7'h00;
        f7List[1]    = 7'h20;
        f7List[2]    = 7'h01;
        pushedCount  = 0;
        checkedCount = 0;
        reset        = 1'b1;
        instr        = '0;
        instrValid   = 1'b0;
        driveInstr(1'b0, 32'h0);
        driveInstr(1'b0, 32'h0);
        reset = 1'b0;
        driveInstr(1'b0, 32'h0);

        // Directed sweep over every funct3 of each class
        for (int f3 = 0; f3 < 8; f3++) begin
            for (int k = 0; k < 3; k++) begin
                driveInstr(1'b1, {f7List[k], 5'd7, 5'd6, f3[2:0], 5'd5, OpReg});
                driveInstr(1'b1, {f7List[k], 5'd9, 5'd6, f3[2:0], 5'd5, OpImm});
            end
            driveInstr(1'b1, {12'h123, 5'd2, f3[2:0], 5'd1, OpLoad});
            driveInstr(1'b1, {7'h10, 5'd3, 5'd2, f3[2:0], 5'd4, OpStore});
            driveInstr(1'b1, {7'h05, 5'd3, 5'd2, f3[2:0], 5'd8, OpBranch});
            driveInstr(1'b1, {12'hff0, 5'd2, f3[2:0], 5'd1, OpJalr});
        end
        driveInstr(1'b1, {20'hABCDE, 5'd1, OpLui});
        driveInstr(1'b1, {20'h12345, 5'd1, OpAuipc});
        driveInstr(1'b0, 32'h0);
        driveInstr(1'b1, {20'h80101, 5'd1, OpJal});
        driveInstr(1'b1, 32'h0000_0000);
        driveInstr(1'b1, 32'hFFFF_FFFF);
        driveInstr(1'b1, 32'h0000_000F);
        driveInstr(1'b1, 32'h0000_0073);

        for (int i = 0; i < RandomCount; i++) begin
            driveInstr($urandom_range(0, 3) != 0, randomInstr());
        end
        driveInstr(1'b0, 32'h0);

        while (checkedCount != pushedCount) begin
            @(posedge clk);
        end
        // Assertions on the last outputs resolve at this edge
        @(negedge clk);
        if (DUT.chk.failCount != 0) begin
            $display("Bound checker saw %0d assertion failures", DUT.chk.failCount);
            $display("TESTBENCH FAILED");
            $fatal(1, "Checker assertion failure");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule
